// File: logic/ci_macros.svh
`ifndef CI_MACROS_SVH
`define CI_MACROS_SVH

////////////////////////////////
// CPU side widths
////////////////////////////////

// Word address, byte addressing is not used
`define CI_ADDR_BITS 30
`define CI_DATA_BITS 32
`define CI_BE_BITS 4

////////////////////////////////
// Cache geometry
////////////////////////////////

// 16 single-word lines per cache
`define CI_INDEX_BITS 4

////////////////////////////////
// Main memory
////////////////////////////////

// 1024 words deep
`define CI_MEM_ADDR_BITS 10
// Cycles from accept to done
`define CI_MEM_LATENCY 8

`endif

// File: logic/ci_pkg.sv
`include "ci_macros.svh"

package ci_pkg;

    ////////////////////////////////
    // Vector types
    ////////////////////////////////

    typedef logic [`CI_ADDR_BITS-1:0] word_addr_t;
    typedef logic [`CI_DATA_BITS-1:0] word_t;
    typedef logic [`CI_BE_BITS-1:0] byte_en_t;

    // Low address bits pick the line, the rest is the tag
    typedef logic [`CI_INDEX_BITS-1:0] cache_index_t;
    typedef logic [`CI_ADDR_BITS-`CI_INDEX_BITS-1:0] cache_tag_t;

    ////////////////////////////////
    // Memory channel
    ////////////////////////////////

    // Held steady by the requester until done
    typedef struct packed {
        logic       req;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
        byte_en_t   byte_en;
    } mem_req_t;

    // done is a single-cycle pulse
    typedef struct packed {
        logic  done;
        word_t rdata;
    } mem_rsp_t;

    ////////////////////////////////
    // State machines
    ////////////////////////////////

    typedef enum logic [1:0] {C_IDLE, C_MISS, C_FILL} cache_state_t;
    typedef enum logic {M_IDLE, M_BUSY} mem_state_t;

endpackage

// File: logic/icache.sv
`timescale 1ns/1ps
`include "ci_macros.svh"

module icache (
    input  logic               clk,
    input  logic               rst,
    input  ci_pkg::word_addr_t ic_addr,
    output ci_pkg::word_t      ic_data,
    output logic               ic_miss,
    output ci_pkg::mem_req_t   mreq,
    input  ci_pkg::mem_rsp_t   mrsp
);

    localparam int LINES = 1 << `CI_INDEX_BITS;

    ci_pkg::cache_state_t state_q;
    logic [LINES-1:0]     valid_q;
    ci_pkg::cache_tag_t   tag_q [LINES];
    ci_pkg::word_t        data_q [LINES];
    ci_pkg::word_addr_t   miss_addr_q;
    logic                 fetch_on_q;

    ci_pkg::cache_index_t idx;
    ci_pkg::cache_tag_t   tag;
    ci_pkg::cache_index_t miss_idx;
    ci_pkg::cache_tag_t   miss_tag;
    logic                 hit;

    assign idx      = ic_addr[`CI_INDEX_BITS-1:0];
    assign tag      = ic_addr[`CI_ADDR_BITS-1:`CI_INDEX_BITS];
    assign miss_idx = miss_addr_q[`CI_INDEX_BITS-1:0];
    assign miss_tag = miss_addr_q[`CI_ADDR_BITS-1:`CI_INDEX_BITS];

    // Lookup straight from the arrays, no extra cycle on a hit
    assign hit     = valid_q[idx] && (tag_q[idx] == tag);
    assign ic_data = data_q[idx];
    assign ic_miss = fetch_on_q && !hit;

    // Refill request, always a read
    always_comb begin
        mreq         = '0;
        mreq.req     = (state_q == ci_pkg::C_MISS);
        mreq.addr    = miss_addr_q;
        mreq.byte_en = '1;
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ci_pkg::C_IDLE;
            valid_q    <= '0;
            fetch_on_q <= 1'b0;
        end else begin
            // Fetch is held off for one cycle after reset
            fetch_on_q <= 1'b1;
            case (state_q)
                ci_pkg::C_IDLE: begin
                    if (ic_miss) begin
                        state_q <= ci_pkg::C_MISS;
                    end
                end
                ci_pkg::C_MISS: begin
                    if (mrsp.done) begin
                        valid_q[miss_idx] <= 1'b1;
                        state_q           <= ci_pkg::C_FILL;
                    end
                end
                default: begin
                    state_q <= ci_pkg::C_IDLE;
                end
            endcase
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (state_q == ci_pkg::C_IDLE) begin
            miss_addr_q <= ic_addr;
        end
        if (state_q == ci_pkg::C_MISS && mrsp.done) begin
            tag_q[miss_idx]  <= miss_tag;
            data_q[miss_idx] <= mrsp.rdata;
        end
    end

endmodule

// File: logic/dcache.sv
`timescale 1ns/1ps
`include "ci_macros.svh"

module dcache (
    input  logic               clk,
    input  logic               rst,
    input  logic               dc_read,
    input  logic               dc_write,
    input  ci_pkg::word_addr_t dc_addr,
    input  ci_pkg::word_t      dc_wdata,
    input  ci_pkg::byte_en_t   dc_byte_en,
    output ci_pkg::word_t      dc_data,
    output logic               dc_busy,
    output ci_pkg::mem_req_t   mreq,
    input  ci_pkg::mem_rsp_t   mrsp
);

    localparam int LINES = 1 << `CI_INDEX_BITS;

    ci_pkg::cache_state_t state_q;
    logic [LINES-1:0]     valid_q;
    ci_pkg::cache_tag_t   tag_q [LINES];
    ci_pkg::word_t        data_q [LINES];
    ci_pkg::mem_req_t     pend_q;

    ci_pkg::cache_index_t idx;
    ci_pkg::cache_tag_t   tag;
    ci_pkg::cache_index_t pend_idx;
    ci_pkg::cache_tag_t   pend_tag;
    logic                 hit;
    logic                 pend_hit;
    logic                 start;
    logic                 fill_done;

    assign idx      = dc_addr[`CI_INDEX_BITS-1:0];
    assign tag      = dc_addr[`CI_ADDR_BITS-1:`CI_INDEX_BITS];
    assign pend_idx = pend_q.addr[`CI_INDEX_BITS-1:0];
    assign pend_tag = pend_q.addr[`CI_ADDR_BITS-1:`CI_INDEX_BITS];

    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign pend_hit = valid_q[pend_idx] && (tag_q[pend_idx] == pend_tag);
    assign dc_data  = data_q[idx];

    // Every write goes to memory and a read only on a miss
    assign start     = (state_q == ci_pkg::C_IDLE) && (dc_write || (dc_read && !hit));
    assign fill_done = (state_q == ci_pkg::C_MISS) && mrsp.done;
    assign dc_busy   = start || (state_q == ci_pkg::C_MISS);

    // Request goes out straight from the pending register
    assign mreq = pend_q;

    ////////////////////////////////
    // Control state
    ////////////////////////////////

    // A write that is still presented after its fill is sent again,
    // which leaves memory unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ci_pkg::C_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                ci_pkg::C_IDLE: begin
                    if (start) begin
                        state_q <= ci_pkg::C_MISS;
                    end
                end
                ci_pkg::C_MISS: begin
                    if (mrsp.done) begin
                        // No allocate on a write miss
                        if (!pend_q.write) begin
                            valid_q[pend_idx] <= 1'b1;
                        end
                        state_q <= ci_pkg::C_FILL;
                    end
                end
                default: begin
                    state_q <= ci_pkg::C_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////
    // Request and line update
    ////////////////////////////////

    always_ff @(posedge clk) begin
        // req rises with start and drops on done
        if (rst) begin
            pend_q.req <= 1'b0;
        end else if (state_q == ci_pkg::C_IDLE) begin
            pend_q.req <= start;
        end else if (fill_done) begin
            pend_q.req <= 1'b0;
        end
        if (state_q == ci_pkg::C_IDLE) begin
            pend_q.write   <= dc_write;
            pend_q.addr    <= dc_addr;
            pend_q.wdata   <= dc_wdata;
            pend_q.byte_en <= dc_byte_en;
        end
        if (fill_done) begin
            if (!pend_q.write) begin
                tag_q[pend_idx]  <= pend_tag;
                data_q[pend_idx] <= mrsp.rdata;
            end else if (pend_hit) begin
                // Merge enabled bytes into the cached word
                for (int b = 0; b < `CI_BE_BITS; b++) begin
                    if (pend_q.byte_en[b]) begin
                        data_q[pend_idx][8*b +: 8] <= pend_q.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  ci_pkg::mem_req_t ic_mreq,
    input  ci_pkg::mem_req_t dc_mreq,
    output ci_pkg::mem_rsp_t ic_mrsp,
    output ci_pkg::mem_rsp_t dc_mrsp,
    output ci_pkg::mem_req_t mem_req,
    input  ci_pkg::mem_rsp_t mem_rsp,
    input  logic             ic_miss,
    input  logic             dc_busy,
    output logic             mem_stall
);

    // Grant owner, valid while busy_q is set
    logic busy_q;
    logic grant_dc_q;

    ////////////////////////////////
    // Grant
    ////////////////////////////////

    // Data side wins a tie, grant held until done
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            grant_dc_q <= 1'b0;
        end else if (!busy_q) begin
            if (dc_mreq.req) begin
                busy_q     <= 1'b1;
                grant_dc_q <= 1'b1;
            end else if (ic_mreq.req) begin
                busy_q     <= 1'b1;
                grant_dc_q <= 1'b0;
            end
        end else if (mem_rsp.done) begin
            busy_q <= 1'b0;
        end
    end

    ////////////////////////////////
    // Routing
    ////////////////////////////////

    always_comb begin
        mem_req = '0;
        if (busy_q) begin
            mem_req = grant_dc_q ? dc_mreq : ic_mreq;
        end
    end

    // Read data fans out, done goes to the owner only
    always_comb begin
        ic_mrsp.rdata = mem_rsp.rdata;
        dc_mrsp.rdata = mem_rsp.rdata;
        ic_mrsp.done  = mem_rsp.done && busy_q && !grant_dc_q;
        dc_mrsp.done  = mem_rsp.done && busy_q && grant_dc_q;
    end

    // Either port holds the whole CPU
    assign mem_stall = ic_miss | dc_busy;

endmodule

// File: logic/main_mem.sv
`timescale 1ns/1ps
`include "ci_macros.svh"

module main_mem (
    input  logic             clk,
    input  logic             rst,
    input  ci_pkg::mem_req_t mem_req,
    output ci_pkg::mem_rsp_t mem_rsp
);

    localparam int DEPTH    = 1 << `CI_MEM_ADDR_BITS;
    localparam int CNT_BITS = $clog2(`CI_MEM_LATENCY);

    ci_pkg::word_t      mem [DEPTH];
    ci_pkg::mem_state_t state_q;
    logic [CNT_BITS-1:0] cnt_q;
    logic               done_q;
    ci_pkg::word_t      rdata_q;

    logic [`CI_MEM_ADDR_BITS-1:0] waddr;
    logic                         last;

    assign waddr = mem_req.addr[`CI_MEM_ADDR_BITS-1:0];
    assign last  = (state_q == ci_pkg::M_BUSY)
                   && (cnt_q == CNT_BITS'(`CI_MEM_LATENCY - 1));

    assign mem_rsp.done  = done_q;
    assign mem_rsp.rdata = rdata_q;

    // Each word starts out as its own address with a marker pattern
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hA500_0000 | ci_pkg::word_t'(i);
        end
    end

    ////////////////////////////////
    // Latency counter
    ////////////////////////////////

    // Requester still holds req during the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ci_pkg::M_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == ci_pkg::M_IDLE) begin
                if (mem_req.req && !done_q) begin
                    state_q <= ci_pkg::M_BUSY;
                    cnt_q   <= '0;
                end
            end else if (last) begin
                done_q  <= 1'b1;
                state_q <= ci_pkg::M_IDLE;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Array access on the final count
    always_ff @(posedge clk) begin
        if (last) begin
            rdata_q <= mem[waddr];
            if (mem_req.write) begin
                for (int b = 0; b < `CI_BE_BITS; b++) begin
                    if (mem_req.byte_en[b]) begin
                        mem[waddr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: logic/cpu_interface.sv
`timescale 1ns/1ps

module cpu_interface (
    input  logic               clk,
    input  logic               rst,
    input  ci_pkg::word_addr_t ic_addr,
    input  logic               dc_read,
    input  logic               dc_write,
    input  ci_pkg::word_addr_t dc_addr,
    input  ci_pkg::word_t      dc_wdata,
    input  ci_pkg::byte_en_t   dc_byte_en,
    output ci_pkg::word_t      ic_data,
    output ci_pkg::word_t      dc_data,
    output logic               mem_stall
);

    // Cache miss channels
    ci_pkg::mem_req_t ic_mreq;
    ci_pkg::mem_rsp_t ic_mrsp;
    ci_pkg::mem_req_t dc_mreq;
    ci_pkg::mem_rsp_t dc_mrsp;

    // Shared memory channel
    ci_pkg::mem_req_t mem_req;
    ci_pkg::mem_rsp_t mem_rsp;

    logic ic_miss;
    logic dc_busy;

    icache u_icache (
        .clk     (clk),
        .rst     (rst),
        .ic_addr (ic_addr),
        .ic_data (ic_data),
        .ic_miss (ic_miss),
        .mreq    (ic_mreq),
        .mrsp    (ic_mrsp)
    );

    dcache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .dc_read    (dc_read),
        .dc_write   (dc_write),
        .dc_addr    (dc_addr),
        .dc_wdata   (dc_wdata),
        .dc_byte_en (dc_byte_en),
        .dc_data    (dc_data),
        .dc_busy    (dc_busy),
        .mreq       (dc_mreq),
        .mrsp       (dc_mrsp)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .ic_mreq   (ic_mreq),
        .dc_mreq   (dc_mreq),
        .ic_mrsp   (ic_mrsp),
        .dc_mrsp   (dc_mrsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .ic_miss   (ic_miss),
        .dc_busy   (dc_busy),
        .mem_stall (mem_stall)
    );

    main_mem u_main_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: dv/ci_assertions.sv
`timescale 1ns/1ps

module ci_assertions (
    input logic             clk,
    input logic             rst,
    input ci_pkg::mem_req_t ic_mreq,
    input ci_pkg::mem_rsp_t ic_mrsp,
    input ci_pkg::mem_req_t dc_mreq,
    input ci_pkg::mem_rsp_t dc_mrsp,
    input ci_pkg::mem_req_t mem_req,
    input ci_pkg::mem_rsp_t mem_rsp,
    input logic             mem_stall
);

    // Number of failed assertions
    int fail_count;

    ////////////////////////////////
    // Request held until done
    ////////////////////////////////

    ic_req_steady: assert property (@(posedge clk) disable iff (rst)
        (ic_mreq.req && !ic_mrsp.done) |=> $stable(ic_mreq))
        else begin
            fail_count++;
            $error("icache request changed before done");
        end

    dc_req_steady: assert property (@(posedge clk) disable iff (rst)
        (dc_mreq.req && !dc_mrsp.done) |=> $stable(dc_mreq))
        else begin
            fail_count++;
            $error("dcache request changed before done");
        end

    mem_req_steady: assert property (@(posedge clk) disable iff (rst)
        (mem_req.req && !mem_rsp.done) |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request changed before done");
        end

    // Single-cycle done
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.done |=> !mem_rsp.done)
        else begin
            fail_count++;
            $error("memory done longer than one cycle");
        end

    // Stall quiet in reset
    stall_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !mem_stall)
        else begin
            fail_count++;
            $error("mem_stall high during reset");
        end

endmodule

bind cpu_interface ci_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .ic_mreq   (ic_mreq),
    .ic_mrsp   (ic_mrsp),
    .dc_mreq   (dc_mreq),
    .dc_mrsp   (dc_mrsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .mem_stall (mem_stall)
);

// File: dv/ci_tb.sv
`timescale 1ns/1ps
`include "ci_macros.svh"

module ci_tb;

    localparam int HALF       = 10;
    localparam int PERIOD     = 2 * HALF;
    localparam int RST_CYCLES = 16;
    localparam int MAX_REQ    = 64;
    localparam int FIELDS     = 5;
    localparam int MEM_DEPTH  = 1 << `CI_MEM_ADDR_BITS;

    // Op codes used in the stimulus file
    localparam logic [31:0] OP_FETCH = 32'd0;
    localparam logic [31:0] OP_READ  = 32'd1;
    localparam logic [31:0] OP_WRITE = 32'd2;

    logic               clk;
    logic               rst;
    ci_pkg::word_addr_t ic_addr;
    logic               dc_read;
    logic               dc_write;
    ci_pkg::word_addr_t dc_addr;
    ci_pkg::word_t      dc_wdata;
    ci_pkg::byte_en_t   dc_byte_en;
    ci_pkg::word_t      ic_data;
    ci_pkg::word_t      dc_data;
    logic               mem_stall;

    logic [31:0]   stim [FIELDS*MAX_REQ];
    ci_pkg::word_t model_mem [MEM_DEPTH];
    int            num_req;
    int            word_errors;
    int            stall_errors;
    int            setup_errors;
    int            assert_errors;
    logic          loaded;

    cpu_interface u_dut (
        .clk        (clk),
        .rst        (rst),
        .ic_addr    (ic_addr),
        .dc_read    (dc_read),
        .dc_write   (dc_write),
        .dc_addr    (dc_addr),
        .dc_wdata   (dc_wdata),
        .dc_byte_en (dc_byte_en),
        .ic_data    (ic_data),
        .dc_data    (dc_data),
        .mem_stall  (mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    // Power-up content is the address ORed with a marker
    function automatic ci_pkg::word_t initial_word(input int unsigned a);
        return 32'hA500_0000 | ci_pkg::word_t'(a);
    endfunction

    function automatic ci_pkg::word_t merge_bytes(input ci_pkg::word_t old_word,
                                                  input ci_pkg::word_t new_word,
                                                  input ci_pkg::byte_en_t be);
        ci_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < `CI_BE_BITS; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////
    // Compare tasks
    ////////////////////////////////

    task automatic check_word(input string name, input ci_pkg::word_t got,
                              input ci_pkg::word_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stall_errors++;
            $display("FAILED at %0t ns: mem_stall got %b expected %b", $time, got, exp);
        end
    endtask

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    task automatic load_stimulus;
        for (int i = 0; i < FIELDS*MAX_REQ; i++) begin
            stim[i] = '1;
        end
        $readmemh("dv/ci_stimulus.txt", stim);
        num_req = 0;
        // All ones in the op column marks the end
        while (num_req < MAX_REQ && stim[FIELDS*num_req] != '1) begin
            num_req++;
        end
        if (num_req == 0) begin
            setup_errors++;
            $display("Stimulus file dv/ci_stimulus.txt held no requests");
        end
    endtask

    // One CPU request held until mem_stall is low
    task automatic run_request(input int n);
        logic [31:0]        op;
        ci_pkg::word_addr_t ia;
        ci_pkg::word_addr_t da;
        ci_pkg::word_t      wd;
        ci_pkg::byte_en_t   be;
        op = stim[FIELDS*n];
        ia = stim[FIELDS*n+1][`CI_ADDR_BITS-1:0];
        da = stim[FIELDS*n+2][`CI_ADDR_BITS-1:0];
        wd = stim[FIELDS*n+3];
        be = stim[FIELDS*n+4][`CI_BE_BITS-1:0];
        if (op != OP_FETCH && op != OP_READ && op != OP_WRITE) begin
            setup_errors++;
            $display("Stimulus line %0d has an unknown op %h", n, op);
        end
        @(negedge clk);
        ic_addr    <= ia;
        dc_read    <= (op == OP_READ);
        dc_write   <= (op == OP_WRITE);
        dc_addr    <= da;
        dc_wdata   <= wd;
        dc_byte_en <= be;
        #1;
        while (mem_stall !== 1'b0) begin
            @(negedge clk);
            #1;
        end
        // Stall is low, so the next rising edge completes the access
        check_word("ic_data", ic_data, model_mem[ia[`CI_MEM_ADDR_BITS-1:0]]);
        if (op == OP_READ) begin
            check_word("dc_data", dc_data, model_mem[da[`CI_MEM_ADDR_BITS-1:0]]);
        end
        if (op == OP_WRITE) begin
            model_mem[da[`CI_MEM_ADDR_BITS-1:0]] =
                merge_bytes(model_mem[da[`CI_MEM_ADDR_BITS-1:0]], wd, be);
        end
        @(posedge clk);
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        word_errors   = 0;
        stall_errors  = 0;
        setup_errors  = 0;
        assert_errors = 0;
        loaded        = 1'b0;
        rst           = 1'b1;
        ic_addr       = '0;
        dc_read       = 1'b0;
        dc_write      = 1'b0;
        dc_addr       = '0;
        dc_wdata      = '0;
        dc_byte_en    = '0;

        load_stimulus();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model_mem[i] = initial_word(i);
        end
        loaded = 1'b1;

        // Stall must stay low while reset is held
        for (int c = 0; c < RST_CYCLES; c++) begin
            @(negedge clk);
            if (c >= 2) begin
                check_stall(mem_stall, 1'b0);
            end
        end
        rst <= 1'b0;
        // Fetch is enabled one edge after reset
        @(posedge clk);

        for (int n = 0; n < num_req; n++) begin
            run_request(n);
        end

        @(negedge clk);
        dc_read  <= 1'b0;
        dc_write <= 1'b0;

        assert_errors = u_dut.u_assertions.fail_count;
        $display("Error counts: word=%0d stall=%0d setup=%0d assert=%0d",
                 word_errors, stall_errors, setup_errors, assert_errors);
        if (word_errors == 0 && stall_errors == 0 && setup_errors == 0
            && assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Four memory latencies per request covers a miss on both ports
    initial begin
        wait (loaded);
        #(num_req * 4 * `CI_MEM_LATENCY * PERIOD + (RST_CYCLES + 2) * PERIOD);
        $display("Watchdog expired before all requests completed");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: dv/ci_stimulus.txt
// Columns in hex: op ic_addr dc_addr wdata byte_en
// op 0 is fetch only, 1 is a data read, 2 is a data write
0 00000000 00000000 00000000 0
0 00000000 00000000 00000000 0
0 00000001 00000000 00000000 0
1 00000002 00000010 00000000 0
1 00000002 00000010 00000000 0
1 00000003 00000021 00000000 0
2 00000003 00000021 DEADBEEF F
1 00000004 00000021 00000000 0
2 00000004 00000021 11223344 5
1 00000004 00000021 00000000 0
2 00000005 00000033 CAFEF00D 2
1 00000005 00000033 00000000 0
2 00000005 00000034 AABBCCDD F
1 00000006 00000034 00000000 0
2 00000006 00000034 00000077 8
1 00000006 00000034 00000000 0
2 00000006 00000040 10000040 F
1 00000006 00000040 00000000 0
2 00000006 00000140 20000140 F
1 00000007 00000140 00000000 0
1 00000007 00000040 00000000 0
2 00000007 00000340 30000340 3
1 00000008 00000340 00000000 0
1 00000008 00000140 00000000 0
2 00000008 00000040 44444444 C
1 00000009 00000040 00000000 0
1 00000009 00000340 00000000 0
1 00000050 00000050 00000000 0
1 00000060 00000060 00000000 0
1 00000151 00000151 00000000 0
1 00000200 00000200 00000000 0

// File: sources.f
+incdir+logic
logic/ci_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/main_mem.sv
logic/cpu_interface.sv
dv/ci_assertions.sv
dv/ci_tb.sv

// File: Makefile
# Verilator simulation of cpu_interface

SIM := obj_dir/ci_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): sources.f logic/*.sv logic/*.svh dv/*.sv
	verilator --binary --timing --assert -f sources.f --top-module ci_tb \
		--Mdir obj_dir -o ci_sim

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
